//--- design/exec_pkg.sv
// shared widths, alu function codes and the issue / bus structs of the execution back end
// every rtl file refers to these by exec_pkg:: scoped names
`default_nettype none

package exec_pkg;

	////////////////////
	// widths
	////////////////////
	localparam int unsigned xlen      = 64;                 // operand and result width
	localparam int unsigned num_pregs = 64;                 // physical registers
	localparam int unsigned preg_w    = $clog2(num_pregs);  // physical tag width

	// alu operation select, the multiplier ignores it
	typedef enum logic [2:0] {
		alu_add   = 3'd0,
		alu_sub   = 3'd1,
		alu_and   = 3'd2,
		alu_or    = 3'd3,
		alu_xor   = 3'd4,
		alu_sll   = 3'd5,   // shift amount is opb[5:0]
		alu_srl   = 3'd6,
		alu_cmplt = 3'd7    // signed less-than, gives 1 or 0
	} alu_func_e;

	////////////////////
	// payloads
	////////////////////

	// one issued operation, driven by the scheduler side
	typedef struct packed {
		logic                valid;
		alu_func_e           func;
		logic [xlen-1:0]     opa;
		logic [xlen-1:0]     opb;
		logic [preg_w-1:0]   tag;    // destination physical register
	} issue_t;

	// one broadcast on the common data bus
	typedef struct packed {
		logic                valid;
		logic [preg_w-1:0]   tag;
		logic [xlen-1:0]     value;
	} cdb_t;

	// finished result held by a unit until the arbiter grants it
	typedef struct packed {
		logic                req;
		logic [preg_w-1:0]   tag;
		logic [xlen-1:0]     value;
	} fu_result_t;

endpackage

`default_nettype wire

//--- design/alu_unit.sv
// one-cycle integer alu, result parked in a slot until the cdb grant arrives
// instantiated once per alu lane in the execution cluster
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
	input  logic                      clock,
	input  logic                      rst,
	input  exec_pkg::issue_t          issue,    // operation from the scheduler
	output logic                      ready,    // slot free, or freed this cycle
	output exec_pkg::fu_result_t      result,   // request to the cdb arbiter
	input  logic                      grant     // arbiter picked this unit
);

	logic                            req_q;     // slot holds an unsent result
	logic [exec_pkg::preg_w-1:0]     tag_q;
	logic [exec_pkg::xlen-1:0]       value_q;
	logic [exec_pkg::xlen-1:0]       alu_out;
	logic                            accept;

	////////////////////
	// datapath
	////////////////////
	always_comb begin
		case (issue.func)
			exec_pkg::alu_add:   alu_out = issue.opa + issue.opb;
			exec_pkg::alu_sub:   alu_out = issue.opa - issue.opb;
			exec_pkg::alu_and:   alu_out = issue.opa & issue.opb;
			exec_pkg::alu_or:    alu_out = issue.opa | issue.opb;
			exec_pkg::alu_xor:   alu_out = issue.opa ^ issue.opb;
			exec_pkg::alu_sll:   alu_out = issue.opa << issue.opb[5:0];  // low 6 bits only
			exec_pkg::alu_srl:   alu_out = issue.opa >> issue.opb[5:0];  // logical
			exec_pkg::alu_cmplt: begin
				// signed compare, zero extended flag
				alu_out = {{(exec_pkg::xlen-1){1'b0}},
					($signed(issue.opa) < $signed(issue.opb))};
			end
			default:             alu_out = '0;
		endcase
	end

	////////////////////
	// result slot
	////////////////////

	// a granted result leaves at this edge, so a new op may take its place
	assign ready  = ~req_q | grant;
	assign accept = issue.valid & ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			req_q <= 1'b0;
		end else if (accept) begin
			req_q <= 1'b1;          // new result replaces the granted one
		end else if (grant) begin
			req_q <= 1'b0;          // sent on the bus, slot empty
		end
	end

	// payload only moves on accept, held stable while waiting for grant
	always_ff @(posedge clock) begin
		if (accept) begin
			tag_q   <= issue.tag;
			value_q <= alu_out;
		end
	end

	assign result.req   = req_q;
	assign result.tag   = tag_q;
	assign result.value = value_q;

endmodule

`default_nettype wire

//--- design/mult_unit.sv
// pipelined shift-and-add multiplier, low 64 bits of opa*opb
// the whole pipe freezes while its output slot waits for the cdb
`timescale 1ns/1ns
`default_nettype none

module mult_unit #(
	parameter int mult_stages = 4       // pipe depth, 2 or more
) (
	input  logic                      clock,
	input  logic                      rst,
	input  exec_pkg::issue_t          issue,    // func field unused here
	output logic                      ready,
	output exec_pkg::fu_result_t      result,
	input  logic                      grant
);

	// multiplier bits consumed per stage, rounded up
	localparam int chunk_w = (exec_pkg::xlen + mult_stages - 1) / mult_stages;

	typedef struct packed {
		logic                          valid;
		logic [exec_pkg::preg_w-1:0]   tag;
		logic [exec_pkg::xlen-1:0]     mcand;    // opa
		logic [exec_pkg::xlen-1:0]     mplier;   // opb
		logic [exec_pkg::xlen-1:0]     prod;     // partial product so far
	} mstage_t;

	mstage_t                         stage_q [mult_stages];
	mstage_t                         stage_d [mult_stages];
	logic                            slot_req_q;
	logic [exec_pkg::preg_w-1:0]     slot_tag_q;
	logic [exec_pkg::xlen-1:0]       slot_value_q;
	logic                            stall;

	// add in the shifted multiplicand for every set bit of chunk s
	function automatic logic [exec_pkg::xlen-1:0] add_chunk(input mstage_t st, input int s);
		logic [exec_pkg::xlen-1:0] acc;
		int                        idx;
		acc = st.prod;
		for (int j = 0; j < chunk_w; j++) begin
			idx = s * chunk_w + j;
			if (idx < exec_pkg::xlen) begin         // last chunk may run past the top
				if (st.mplier[idx])
					acc = acc + (st.mcand << idx);
			end
		end
		return acc;
	endfunction

	assign stall = slot_req_q & ~grant;    // slot full and not leaving
	assign ready = ~stall;

	////////////////////
	// stage advance
	////////////////////
	always_comb begin
		stage_d[0].valid  = issue.valid & ready;   // stage 0 just latches operands
		stage_d[0].tag    = issue.tag;
		stage_d[0].mcand  = issue.opa;
		stage_d[0].mplier = issue.opb;
		stage_d[0].prod   = '0;
		for (int s = 1; s < mult_stages; s++) begin
			stage_d[s]      = stage_q[s-1];
			stage_d[s].prod = add_chunk(stage_q[s-1], s-1);
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int s = 0; s < mult_stages; s++)
				stage_q[s].valid <= 1'b0;
			slot_req_q <= 1'b0;
		end else if (!stall) begin
			stage_q      <= stage_d;
			// last chunk is added on the way into the slot
			slot_req_q   <= stage_q[mult_stages-1].valid;
			slot_tag_q   <= stage_q[mult_stages-1].tag;
			slot_value_q <= add_chunk(stage_q[mult_stages-1], mult_stages-1);
		end
	end

	assign result.req   = slot_req_q;
	assign result.tag   = slot_tag_q;
	assign result.value = slot_value_q;

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
// round-robin owner of the single common data bus
// grants one held unit result per cycle and broadcasts it on the next
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter #(
	parameter int num_req = 3           // units sharing the bus
) (
	input  logic                                     clock,
	input  logic                                     rst,
	input  exec_pkg::fu_result_t [num_req-1:0]       result,  // held unit results
	output logic [num_req-1:0]                       grant,   // one-hot or zero
	output exec_pkg::cdb_t                           cdb      // registered broadcast
);

	localparam int ptr_w = (num_req > 1) ? $clog2(num_req) : 1;

	logic [ptr_w-1:0]    ptr_q;        // first requester checked this cycle
	logic [ptr_w-1:0]    win_idx;      // granted requester
	logic                any_grant;
	exec_pkg::cdb_t      cdb_q;

	////////////////////
	// grant search
	////////////////////
	always_comb begin
		int unsigned idx;
		grant     = '0;
		win_idx   = '0;
		any_grant = 1'b0;
		// walk from the pointer, wrapping, stop at the first request
		for (int i = 0; i < num_req; i++) begin
			idx = (int'(ptr_q) + i) % num_req;
			if (!any_grant && result[idx].req) begin
				any_grant    = 1'b1;
				win_idx      = idx[ptr_w-1:0];
				grant[idx]   = 1'b1;
			end
		end
	end

	////////////////////
	// pointer and bus
	////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			ptr_q       <= '0;
			cdb_q.valid <= 1'b0;
		end else begin
			if (any_grant) begin
				// next search starts just past the winner
				ptr_q <= (int'(win_idx) == num_req - 1) ? '0 : win_idx + 1'b1;
			end
			cdb_q.valid <= any_grant;           // one cycle pulse per grant
			cdb_q.tag   <= result[win_idx].tag;
			cdb_q.value <= result[win_idx].value;
		end
	end

	assign cdb = cdb_q;

endmodule

`default_nettype wire

//--- design/prf.sv
// physical register file with a ready bit per entry
// written by cdb broadcasts, ready cleared when rename allocates the tag
`timescale 1ns/1ns
`default_nettype none

module prf (
	input  logic                            clock,
	input  logic                            rst,
	input  exec_pkg::cdb_t                  cdb,          // write port
	input  logic                            alloc_valid,  // rename took alloc_tag
	input  logic [exec_pkg::preg_w-1:0]     alloc_tag,
	input  logic [exec_pkg::preg_w-1:0]     rd_tag,       // async read port
	output logic [exec_pkg::xlen-1:0]       rd_value,
	output logic                            rd_ready
);

	logic [exec_pkg::xlen-1:0]       regs_q [exec_pkg::num_pregs];
	logic [exec_pkg::num_pregs-1:0]  rdy_q;        // value present

	////////////////////
	// ready bits
	////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			rdy_q <= '1;                        // everything starts valid
		end else begin
			if (alloc_valid)
				rdy_q[alloc_tag] <= 1'b0;       // waiting for its producer
			// bus write comes last so it wins a same-tag allocate
			if (cdb.valid)
				rdy_q[cdb.tag] <= 1'b1;
		end
	end

	////////////////////
	// value array
	////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < exec_pkg::num_pregs; i++)
				regs_q[i] <= '0;                // architectural zero state
		end else if (cdb.valid) begin
			regs_q[cdb.tag] <= cdb.value;
		end
	end

	// no bypass, a write shows up the cycle after the broadcast
	assign rd_value = regs_q[rd_tag];
	assign rd_ready = rdy_q[rd_tag];

endmodule

`default_nettype wire

//--- design/exec_cluster.sv
// execution back end top, two alus and a multiplier sharing one cdb into the prf
// requester order on the arbiter is alu0, alu1, mult
`timescale 1ns/1ns
`default_nettype none

module exec_cluster #(
	parameter int mult_stages = 4
) (
	input  logic                            clock,
	input  logic                            rst,
	input  exec_pkg::issue_t [1:0]          alu_issue,
	output logic [1:0]                      alu_ready,
	input  exec_pkg::issue_t                mult_issue,
	output logic                            mult_ready,
	input  logic                            alloc_valid,
	input  logic [exec_pkg::preg_w-1:0]     alloc_tag,
	input  logic [exec_pkg::preg_w-1:0]     rd_tag,
	output logic [exec_pkg::xlen-1:0]       rd_value,
	output logic                            rd_ready,
	output exec_pkg::cdb_t                  cdb
);

	localparam int num_fu = 3;          // bus requesters

	exec_pkg::fu_result_t [num_fu-1:0]  fu_result;    // 0 alu0, 1 alu1, 2 mult
	logic [num_fu-1:0]                  fu_grant;

	////////////////////
	// functional units
	////////////////////
	alu_unit alu0 (
		.clock  (clock),
		.rst    (rst),
		.issue  (alu_issue[0]),
		.ready  (alu_ready[0]),
		.result (fu_result[0]),
		.grant  (fu_grant[0])
	);

	alu_unit alu1 (
		.clock  (clock),
		.rst    (rst),
		.issue  (alu_issue[1]),
		.ready  (alu_ready[1]),
		.result (fu_result[1]),
		.grant  (fu_grant[1])
	);

	mult_unit #(.mult_stages(mult_stages)) mult (
		.clock  (clock),
		.rst    (rst),
		.issue  (mult_issue),
		.ready  (mult_ready),
		.result (fu_result[2]),
		.grant  (fu_grant[2])
	);

	////////////////////
	// bus and regfile
	////////////////////
	cdb_arbiter #(.num_req(num_fu)) arb (
		.clock  (clock),
		.rst    (rst),
		.result (fu_result),
		.grant  (fu_grant),
		.cdb    (cdb)               // also the top-level broadcast output
	);

	prf prf_inst (
		.clock       (clock),
		.rst         (rst),
		.cdb         (cdb),
		.alloc_valid (alloc_valid),
		.alloc_tag   (alloc_tag),
		.rd_tag      (rd_tag),
		.rd_value    (rd_value),
		.rd_ready    (rd_ready)
	);

endmodule

`default_nettype wire

//--- dv/exec_cluster_sva.sv
// bus protocol assertions for the cdb arbiter
// attached to every cdb_arbiter instance through the bind at the bottom
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_sva #(
	parameter int num_req = 3
) (
	input logic                                  clock,
	input logic                                  rst,
	input exec_pkg::fu_result_t [num_req-1:0]    result,
	input logic [num_req-1:0]                    grant,
	input exec_pkg::cdb_t                        cdb
);

	logic [num_req-1:0] req;

	always_comb begin
		for (int i = 0; i < num_req; i++)
			req[i] = result[i].req;
	end

	////////////////////
	// grant and bus
	////////////////////
	a_onehot: assert property (@(posedge clock) disable iff (rst) $onehot0(grant))
		else $error("more than one unit granted");
	a_req: assert property (@(posedge clock) disable iff (rst) (grant & ~req) == '0)
		else $error("grant to a unit with no request");
	a_bus: assert property (@(posedge clock) disable iff (rst) (|grant) |=> cdb.valid)
		else $error("grant not followed by a broadcast");
	a_idle: assert property (@(posedge clock) disable iff (rst) !(|grant) |=> !cdb.valid)
		else $error("broadcast without a grant");

	for (genvar i = 0; i < num_req; i++) begin : g_req
		logic [7:0] wait_q;     // cycles spent requesting without grant

		always_ff @(posedge clock) begin
			if (rst || !req[i] || grant[i])
				wait_q <= '0;
			else
				wait_q <= wait_q + 1'b1;
		end

		a_hold: assert property (@(posedge clock) disable iff (rst)
			req[i] && !grant[i] |=> req[i]) else $error("request dropped before grant");
		// round robin bound, num_req-1 others at most go first
		a_fair: assert property (@(posedge clock) disable iff (rst)
			req[i] && wait_q == num_req - 1 |-> grant[i]) else $error("request starved");
	end

endmodule

bind cdb_arbiter exec_cluster_sva #(.num_req(num_req)) arb_sva (
	.clock (clock),
	.rst   (rst),
	.result(result),
	.grant (grant),
	.cdb   (cdb)
);

`default_nettype wire

//--- dv/exec_cluster_tb.sv
// random issue testbench for the execution cluster, bus results checked against a model
// one issue and one allocate per cycle, run through the Makefile
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_tb;

	localparam int num_ops     = 400;
	localparam int max_cycles  = num_ops * 40;   // 40 cycles per op
	localparam int stall_limit = 24;             // longest wait for ready

	logic                            clock;
	logic                            rst;
	exec_pkg::issue_t                iss [3];    // 0 alu0, 1 alu1, 2 mult
	logic [1:0]                      alu_ready;
	logic                            mult_ready;
	logic [2:0]                      fu_ready;
	logic                            alloc_valid;
	logic [exec_pkg::preg_w-1:0]     alloc_tag;
	logic [exec_pkg::preg_w-1:0]     rd_tag;
	logic [exec_pkg::xlen-1:0]       rd_value;
	logic                            rd_ready;
	exec_pkg::cdb_t                  cdb;

	logic [exec_pkg::xlen-1:0]       exp_val [exec_pkg::num_pregs];   // model result per tag
	bit                              busy    [exec_pkg::num_pregs];   // allocated, not yet broadcast
	bit                              by_mult [exec_pkg::num_pregs];
	integer                          seed;
	int                              errors;

	assign fu_ready = {mult_ready, alu_ready};

	exec_cluster #(.mult_stages(4)) exec_cluster_inst (
		.clock(clock), .rst(rst), .alu_issue({iss[1], iss[0]}), .alu_ready(alu_ready),
		.mult_issue(iss[2]), .mult_ready(mult_ready), .alloc_valid(alloc_valid),
		.alloc_tag(alloc_tag), .rd_tag(rd_tag), .rd_value(rd_value), .rd_ready(rd_ready),
		.cdb(cdb)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic note_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// expected result straight from the operation rules
	function automatic logic [63:0] expect_value(input int unit, input exec_pkg::alu_func_e f,
		input logic [63:0] a, input logic [63:0] b);
		if (unit == 2)
			return a * b;   // low 64 bits
		case (f)
			exec_pkg::alu_add: return a + b;
			exec_pkg::alu_sub: return a - b;
			exec_pkg::alu_and: return a & b;
			exec_pkg::alu_or:  return a | b;
			exec_pkg::alu_xor: return a ^ b;
			exec_pkg::alu_sll: return a << b[5:0];
			exec_pkg::alu_srl: return a >> b[5:0];
			default:           return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
		endcase
	endfunction

	// first tag at or after start whose busy bit matches, -1 if none
	function automatic int find_tag(input logic [31:0] start, input bit want_busy);
		int idx;
		for (int i = 0; i < exec_pkg::num_pregs; i++) begin
			idx = (int'(start[5:0]) + i) % exec_pkg::num_pregs;
			if (busy[idx] == want_busy)
				return idx;
		end
		return -1;
	endfunction

	initial begin
		logic [31:0]                   r;
		int                            u;
		int                            t;
		int                            cyc;
		int                            issued;
		int                            outstanding;
		int                            mult_fly;     // mult ops accepted, not yet broadcast
		int                            max_fly;
		int                            waited [3];
		bit                            took   [3];
		bit                            chk_pending;  // read back last broadcast
		bit                            rd_check;
		bit                            exp_rdy;
		logic [exec_pkg::preg_w-1:0]   chk_tag;
		logic [exec_pkg::xlen-1:0]     chk_val;
		seed = 32'hfac2_1079;
		errors = 0;
		rst = 1'b1;
		alloc_valid = 1'b0;
		alloc_tag = '0;
		for (u = 0; u < 3; u++)
			iss[u] = '0;
		r = $random(seed);
		rd_tag = r[exec_pkg::preg_w-1:0];
		repeat (2) @(posedge clock);
		#1 rst = 1'b0;
		@(negedge clock);   // post-reset state
		assert (fu_ready == 3'b111 && !cdb.valid && rd_value == '0 && rd_ready)
			else note_error("state after reset is wrong");
		@(posedge clock);
		#1;
		while ((issued < num_ops || outstanding != 0) && cyc < max_cycles) begin
			////////////////////
			// drive
			////////////////////
			alloc_valid = 1'b0;
			for (u = 0; u < 3; u++) begin
				if (took[u]) iss[u].valid = 1'b0;   // accepted on the last edge
				took[u] = 1'b0;
			end
			rd_check = 1'b0;
			t = find_tag($random(seed), 1'b1);
			if (chk_pending) begin
				rd_tag = chk_tag;
				exp_rdy = 1'b1;
				rd_check = 1'b1;
			end else if (t >= 0) begin
				rd_tag = t[exec_pkg::preg_w-1:0];   // allocated earlier, still waiting
				exp_rdy = 1'b0;
				rd_check = 1'b1;
			end
			r = $random(seed);
			u = r % 3;
			t = find_tag($random(seed), 1'b0);
			if (issued < num_ops && r[31:30] != 2'b00 && !iss[u].valid && t >= 0) begin
				r = $random(seed);
				iss[u].valid = 1'b1;
				iss[u].func = exec_pkg::alu_func_e'(r[2:0]);
				iss[u].opa = {$random(seed), $random(seed)};
				iss[u].opb = {$random(seed), $random(seed)};
				iss[u].tag = t[exec_pkg::preg_w-1:0];
				alloc_valid = 1'b1;
				alloc_tag = t[exec_pkg::preg_w-1:0];
				busy[t] = 1'b1;
				by_mult[t] = (u == 2);
				exp_val[t] = expect_value(u, iss[u].func, iss[u].opa, iss[u].opb);
				waited[u] = 0;
				issued++;
				outstanding++;
			end
			////////////////////
			// sample
			////////////////////
			@(negedge clock);
			if (rd_check)
				assert (rd_ready == exp_rdy && (!exp_rdy || rd_value == chk_val))
					else note_error($sformatf("read tag %0d gave %h ready %b", rd_tag, rd_value,
						rd_ready));
			chk_pending = 1'b0;
			if (cdb.valid) begin
				assert (busy[cdb.tag]) else note_error($sformatf("tag %0d not outstanding", cdb.tag));
				if (busy[cdb.tag]) begin
					assert (cdb.value == exp_val[cdb.tag])
						else note_error($sformatf("tag %0d value %h, expected %h", cdb.tag,
							cdb.value, exp_val[cdb.tag]));
					busy[cdb.tag] = 1'b0;
					if (by_mult[cdb.tag]) mult_fly--;
					outstanding--;
					chk_pending = 1'b1;
					chk_tag = cdb.tag;
					chk_val = exp_val[cdb.tag];
				end
			end
			for (u = 0; u < 3; u++) begin
				if (iss[u].valid && fu_ready[u]) begin
					took[u] = 1'b1;
					if (u == 2) mult_fly++;
					if (mult_fly > max_fly) max_fly = mult_fly;
				end else if (iss[u].valid) begin
					waited[u]++;
					assert (waited[u] != stall_limit)
						else note_error($sformatf("unit %0d never got its ready back", u));
				end
			end
			@(posedge clock);
			#1;
			cyc++;
		end
		if (cyc >= max_cycles) begin
			$display("Timeout: %0d operations still outstanding after %0d cycles", outstanding, cyc);
			errors++;
		end
		assert (max_fly >= 2) else note_error("multiplier never held two operations at once");
		$display("issued %0d, outstanding %0d, cycles %0d, errors %0d", issued, outstanding, cyc,
			errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
design/exec_pkg.sv
design/alu_unit.sv
design/mult_unit.sv
design/cdb_arbiter.sv
design/prf.sv
design/exec_cluster.sv
dv/exec_cluster_sva.sv
dv/exec_cluster_tb.sv

//--- Makefile
# Verilator flow for the execution cluster, override any variable on the command line
VERILATOR ?= verilator
TOP       ?= exec_cluster_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Done: errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
